// File: src/ex_consts.svh
// Widths and depths shared by the execute cluster and its testbench
// The multiplier datapath is laid out for exactly four stages
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Operand and result width
`define EX_DATA_W 64

// Physical register tag, one per PRF entry
`define EX_TAG_W 6

// Reorder-buffer index
`define EX_ROB_W 5

// Multiplier pipeline depth, output register included
`define EX_MULT_STAGES 4

`endif

// File: src/ex_pkg.sv
// Types for the execute cluster; widths come from ex_consts.svh
`include "ex_consts.svh"

package ex_pkg;

  typedef logic [`EX_DATA_W-1:0] data_t;
  typedef logic [`EX_TAG_W-1:0]  tag_t;
  typedef logic [`EX_ROB_W-1:0]  rob_idx_t;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'h0,
    ALU_SUB    = 4'h1,
    ALU_AND    = 4'h2,
    ALU_OR     = 4'h3,
    ALU_XOR    = 4'h4,
    ALU_SLL    = 4'h5,
    ALU_SRL    = 4'h6,
    ALU_CMPEQ  = 4'h7,
    ALU_CMPULT = 4'h8
  } alu_op_t;

  typedef struct packed {
    alu_op_t  op;
    tag_t     tag;
    rob_idx_t rob_idx;
    data_t    a;
    data_t    b;
  } alu_issue_t;

  typedef struct packed {
    tag_t     tag;
    rob_idx_t rob_idx;
    data_t    a;
    data_t    b;
  } mult_issue_t;

  // One broadcast on the common data bus
  typedef struct packed {
    tag_t     tag;
    rob_idx_t rob_idx;
    data_t    value;
  } cdb_t;

endpackage

// File: src/alu_unit.sv
// Single-cycle integer ALU with one output register
// Shifts use only the low log2(data width) bits of b; compares return 0 or 1
module alu_unit import ex_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       in_valid,
  input  alu_issue_t in,
  output logic       in_ready,
  output logic       out_valid,
  output cdb_t       out,
  input  logic       out_ready
);

  localparam int SHAMT_W = $clog2($bits(data_t));

  data_t result;

  // Output slot free, or being emptied this cycle
  assign in_ready = !out_valid || out_ready;

  ////////////////////
  // Datapath

  always_comb
  begin
    case (in.op)
      ALU_ADD:    result = in.a + in.b;  // Wraps
      ALU_SUB:    result = in.a - in.b;
      ALU_AND:    result = in.a & in.b;
      ALU_OR:     result = in.a | in.b;
      ALU_XOR:    result = in.a ^ in.b;
      ALU_SLL:    result = in.a << in.b[SHAMT_W-1:0];
      ALU_SRL:    result = in.a >> in.b[SHAMT_W-1:0];
      ALU_CMPEQ:  result = data_t'(in.a == in.b);
      ALU_CMPULT: result = data_t'(in.a < in.b);  // Unsigned
      default:    result = '0;
    endcase
  end

  ////////////////////
  // Output register

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      out_valid <= 1'b0;
    end
    else if (in_valid && in_ready)
    begin
      out_valid <= 1'b1;
    end
    else if (out_ready)
    begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock)
  begin
    if (in_valid && in_ready)
    begin
      out <= '{tag: in.tag, rob_idx: in.rob_idx, value: result};
    end
  end

  // A waiting result must survive until the arbiter takes it
  a_out_hold: assert property (@(posedge clock) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out)));

endmodule

// File: src/mult_unit.sv
// Pipelined multiplier, low half of the product only
// Stages: partial products, cross-term sum, final add, output register
// Any result stuck in the last stage freezes the whole pipe
`include "ex_consts.svh"

module mult_unit import ex_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        in_valid,
  input  mult_issue_t in,
  output logic        in_ready,
  output logic        out_valid,
  output cdb_t        out,
  input  logic        out_ready
);

  localparam int HALF = $bits(data_t) / 2;

  logic [`EX_MULT_STAGES-1:0] stage_valid;  // Bit 0 is the first stage
  logic                       advance;

  // Stage 1: the three partial products that reach the low half
  tag_t            s1_tag;
  rob_idx_t        s1_rob;
  data_t           s1_ll;
  logic [HALF-1:0] s1_lh;
  logic [HALF-1:0] s1_hl;

  // Stage 2
  tag_t            s2_tag;
  rob_idx_t        s2_rob;
  data_t           s2_ll;
  logic [HALF-1:0] s2_cross;

  // Stage 3
  tag_t            s3_tag;
  rob_idx_t        s3_rob;
  data_t           s3_prod;

  assign advance   = !(stage_valid[`EX_MULT_STAGES-1] && !out_ready);
  assign in_ready  = advance;
  assign out_valid = stage_valid[`EX_MULT_STAGES-1];

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      stage_valid <= '0;
    end
    else if (advance)
    begin
      stage_valid <= {stage_valid[`EX_MULT_STAGES-2:0], in_valid};
    end
  end

  always_ff @(posedge clock)
  begin
    if (advance)
    begin
      s1_tag   <= in.tag;
      s1_rob   <= in.rob_idx;
      s1_ll    <= in.a[HALF-1:0] * in.b[HALF-1:0];
      s1_lh    <= in.a[HALF-1:0] * in.b[2*HALF-1:HALF];  // Upper bits drop out
      s1_hl    <= in.a[2*HALF-1:HALF] * in.b[HALF-1:0];
      s2_tag   <= s1_tag;
      s2_rob   <= s1_rob;
      s2_ll    <= s1_ll;
      s2_cross <= s1_lh + s1_hl;
      s3_tag   <= s2_tag;
      s3_rob   <= s2_rob;
      s3_prod  <= s2_ll + {s2_cross, {HALF{1'b0}}};
      out      <= '{tag: s3_tag, rob_idx: s3_rob, value: s3_prod};
    end
  end

  // Frozen pipe keeps every valid bit and the waiting result
  a_frozen: assert property (@(posedge clock) disable iff (reset)
    !advance |=> ($stable(stage_valid) && $stable(out)));

endmodule

// File: src/cdb_arbiter.sv
// Round-robin merge of the ALU and multiplier results onto one CDB
// The side that lost the last contested cycle wins the next one
module cdb_arbiter import ex_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic alu_valid,
  input  cdb_t alu,
  output logic alu_ready,
  input  logic mult_valid,
  input  cdb_t mult,
  output logic mult_ready,
  output logic cdb_valid,
  output cdb_t cdb,
  input  logic cdb_ready
);

  logic space;       // CDB register empty or draining
  logic alu_won;     // ALU took the last contested cycle
  logic pick_alu;
  logic pick_mult;
  logic grant_alu;
  logic grant_mult;
  logic contested;

  assign space     = !cdb_valid || cdb_ready;
  assign contested = alu_valid && mult_valid;

  ////////////////////
  // Grant

  assign pick_alu  = !mult_valid || !alu_won;
  assign pick_mult = !alu_valid || alu_won;

  assign alu_ready  = space && pick_alu;
  assign mult_ready = space && pick_mult;

  assign grant_alu  = alu_valid && alu_ready;
  assign grant_mult = mult_valid && mult_ready;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      alu_won <= 1'b0;  // First contest goes to the ALU
    end
    else if (contested && space)
    begin
      alu_won <= grant_alu;
    end
  end

  ////////////////////
  // CDB register

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      cdb_valid <= 1'b0;
    end
    else if (grant_alu || grant_mult)
    begin
      cdb_valid <= 1'b1;
    end
    else if (cdb_ready)
    begin
      cdb_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock)
  begin
    if (grant_alu)
    begin
      cdb <= alu;
    end
    else if (grant_mult)
    begin
      cdb <= mult;
    end
  end

  a_one_grant: assert property (@(posedge clock) disable iff (reset)
    !(grant_alu && grant_mult));

  // Consumers sample the bus only on a transfer
  a_cdb_hold: assert property (@(posedge clock) disable iff (reset)
    (cdb_valid && !cdb_ready) |=> (cdb_valid && $stable(cdb)));

endmodule

// File: src/ex_cluster.sv
// Execute and complete cluster: ALU and multiplier sharing one CDB
// Each unit has its own issue port; results meet only in the arbiter
module ex_cluster import ex_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        alu_valid,
  input  alu_issue_t  alu_issue,
  output logic        alu_ready,
  input  logic        mult_valid,
  input  mult_issue_t mult_issue,
  output logic        mult_ready,
  output logic        cdb_valid,
  output cdb_t        cdb,
  input  logic        cdb_ready
);

  // Unit results toward the arbiter
  cdb_t alu_res;
  logic alu_res_valid;
  logic alu_res_ready;
  cdb_t mult_res;
  logic mult_res_valid;
  logic mult_res_ready;

  alu_unit i_alu (
    .clock(clock), .reset(reset),
    .in_valid(alu_valid), .in(alu_issue), .in_ready(alu_ready),
    .out_valid(alu_res_valid), .out(alu_res), .out_ready(alu_res_ready)
  );

  mult_unit i_mult (
    .clock(clock), .reset(reset),
    .in_valid(mult_valid), .in(mult_issue), .in_ready(mult_ready),
    .out_valid(mult_res_valid), .out(mult_res), .out_ready(mult_res_ready)
  );

  cdb_arbiter i_arb (
    .clock(clock), .reset(reset),
    .alu_valid(alu_res_valid), .alu(alu_res), .alu_ready(alu_res_ready),
    .mult_valid(mult_res_valid), .mult(mult_res), .mult_ready(mult_res_ready),
    .cdb_valid(cdb_valid), .cdb(cdb), .cdb_ready(cdb_ready)
  );

endmodule

// File: dv/ex_checker.sv
// Scoreboard for the execute cluster, one expected queue per unit
// Fairness is judged from the unit handshakes inside the DUT
// Latency is checked only while directed is high and cdb_ready stays high
`include "ex_consts.svh"

module ex_checker import ex_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        directed,
  input  logic        alu_valid,
  input  alu_issue_t  alu_issue,
  input  logic        alu_ready,
  input  logic        mult_valid,
  input  mult_issue_t mult_issue,
  input  logic        mult_ready,
  input  logic        cdb_valid,
  input  cdb_t        cdb,
  input  logic        cdb_ready,
  input  logic        alu_res_valid,
  input  logic        alu_res_ready,
  input  logic        mult_res_valid,
  output int          checks,
  output int          errors,
  output int          pending
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ALU_TAGS = 2 ** (`EX_TAG_W - 1);  // Upper half is the multiplier's

  cdb_t alu_q[$];
  cdb_t mult_q[$];
  int   accept_cycle [2**`EX_TAG_W];
  int   cycle;
  logic after_reset;
  logic held;          // CDB was waiting last cycle
  cdb_t held_cdb;
  logic contest_seen;
  logic last_alu_won;

  ////////////////////
  // Reference model

  function automatic data_t ref_alu(alu_op_t op, data_t a, data_t b);
    case (op)
      ALU_ADD:    return a + b;
      ALU_SUB:    return a - b;
      ALU_AND:    return a & b;
      ALU_OR:     return a | b;
      ALU_XOR:    return a ^ b;
      ALU_SLL:    return a << b[5:0];
      ALU_SRL:    return a >> b[5:0];
      ALU_CMPEQ:  return (a == b) ? data_t'(1) : data_t'(0);
      ALU_CMPULT: return (a < b) ? data_t'(1) : data_t'(0);
      default:    return '0;
    endcase
  endfunction

  function automatic data_t ref_mult(data_t a, data_t b);
    logic [2*`EX_DATA_W-1:0] full;
    full = {{`EX_DATA_W{1'b0}}, a} * {{`EX_DATA_W{1'b0}}, b};
    return full[`EX_DATA_W-1:0];  // Low half only
  endfunction

  task automatic compare(input string name, input data_t expected, input data_t actual);
    if (expected !== actual)
    begin
      errors++;
      $display("Error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic check_cdb();
    cdb_t  exp;
    string name;
    int    latency;
    checks++;
    if (cdb.tag < ALU_TAGS ? alu_q.size() == 0 : mult_q.size() == 0)
    begin
      errors++;
      $display("CDB carried tag %0d but no operation with that tag was outstanding", cdb.tag);
      return;
    end
    exp     = (cdb.tag < ALU_TAGS) ? alu_q.pop_front() : mult_q.pop_front();
    latency = (cdb.tag < ALU_TAGS) ? 2 : `EX_MULT_STAGES + 1;
    if (cdb.tag !== exp.tag)
    begin
      errors++;
      $display("CDB carried tag %0d while tag %0d was next in issue order", cdb.tag, exp.tag);
      return;
    end
    name = $sformatf("%s tag %0d", (cdb.tag < ALU_TAGS) ? "alu" : "mult", cdb.tag);
    compare({name, " rob_idx"}, data_t'(exp.rob_idx), data_t'(cdb.rob_idx));
    compare({name, " value"}, exp.value, cdb.value);
    if (directed)
      compare({name, " latency"}, data_t'(latency), data_t'(cycle - accept_cycle[cdb.tag]));
  endtask

  ////////////////////
  // Monitor

  always @(posedge clock)
  begin
    logic alu_won;
    cycle++;
    if (reset)
    begin
      alu_q.delete();
      mult_q.delete();
      held         = 1'b0;
      contest_seen = 1'b0;
      after_reset  = 1'b1;
    end
    else
    begin
      if (after_reset && (cdb_valid || !alu_ready || !mult_ready))
      begin
        errors++;
        $display("DUT not idle after reset: cdb_valid %b, alu_ready %b, mult_ready %b",
                 cdb_valid, alu_ready, mult_ready);
      end
      after_reset = 1'b0;
      if (held && (!cdb_valid || cdb !== held_cdb))
      begin
        errors++;
        $display("CDB dropped or changed its result while waiting for cdb_ready");
      end
      held     = cdb_valid && !cdb_ready;
      held_cdb = cdb;
      if (alu_valid && alu_ready)
      begin
        alu_q.push_back('{tag: alu_issue.tag, rob_idx: alu_issue.rob_idx,
                          value: ref_alu(alu_issue.op, alu_issue.a, alu_issue.b)});
        accept_cycle[alu_issue.tag] = cycle;
      end
      if (mult_valid && mult_ready)
      begin
        mult_q.push_back('{tag: mult_issue.tag, rob_idx: mult_issue.rob_idx,
                           value: ref_mult(mult_issue.a, mult_issue.b)});
        accept_cycle[mult_issue.tag] = cycle;
      end
      // Nothing may stall while the CDB is always ready
      if (directed && ((alu_valid && !alu_ready) || (mult_valid && !mult_ready)))
      begin
        errors++;
        $display("An issue was refused in the directed phase although the CDB was always ready");
      end
      if (cdb_valid && cdb_ready)
        check_cdb();
      // Contested cycle with room in the CDB register
      if (alu_res_valid && mult_res_valid && (!cdb_valid || cdb_ready))
      begin
        alu_won = alu_res_ready;
        if (contest_seen && alu_won == last_alu_won)
        begin
          errors++;
          $display("Arbiter gave the %s two contested cycles in a row",
                   alu_won ? "ALU" : "multiplier");
        end
        contest_seen = 1'b1;
        last_alu_won = alu_won;
      end
      pending = alu_q.size() + mult_q.size();
    end
  end

endmodule

// File: dv/tb_ex_cluster.sv
// Random issue on both ports under random CDB back-pressure,
// then a directed phase with the CDB always ready
// ALU ops use tags 0 to 31, multiplier ops tags 32 to 63
`include "ex_consts.svh"

module tb_ex_cluster import ex_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          NUM_ALU        = 300;
  localparam int          NUM_MULT       = 150;
  localparam int          NUM_DIRECTED   = 20;
  localparam int          NUM_TOTAL      = NUM_ALU + NUM_MULT + NUM_DIRECTED;
  localparam int          TIMEOUT_CYCLES = NUM_TOTAL * 20 + 200;
  localparam int          ALU_TAGS       = 2 ** (`EX_TAG_W - 1);
  localparam logic [31:0] SEED           = 32'h209a_f4f2;

  logic        clock = 1'b0;
  logic        reset = 1'b1;
  logic        alu_valid = 1'b0;
  alu_issue_t  alu_issue = '0;
  logic        alu_ready;
  logic        mult_valid = 1'b0;
  mult_issue_t mult_issue = '0;
  logic        mult_ready;
  logic        cdb_valid;
  cdb_t        cdb;
  logic        cdb_ready = 1'b0;
  logic        random_phase = 1'b1;
  logic        directed = 1'b0;
  logic        alu_fire;    // Issue taken at the last rising edge
  logic        mult_fire;
  logic [2**`EX_TAG_W-1:0] tag_busy;
  int          alu_count;
  int          mult_count;
  int          checks;
  int          errors;
  int          pending;

  always #5 clock = ~clock;

  ex_cluster i_dut (.*);

  ex_checker i_checker (
    .clock, .reset, .directed,
    .alu_valid, .alu_issue, .alu_ready, .mult_valid, .mult_issue, .mult_ready,
    .cdb_valid, .cdb, .cdb_ready,
    .alu_res_valid(i_dut.alu_res_valid), .alu_res_ready(i_dut.alu_res_ready),
    .mult_res_valid(i_dut.mult_res_valid),
    .checks, .errors, .pending
  );

  // Tags in flight, from acceptance to CDB transfer
  always @(posedge clock)
  begin
    alu_fire  <= alu_valid && alu_ready;
    mult_fire <= mult_valid && mult_ready;
    if (reset)
      tag_busy <= '0;
    else
    begin
      if (alu_valid && alu_ready)
        tag_busy[alu_issue.tag] <= 1'b1;
      if (mult_valid && mult_ready)
        tag_busy[mult_issue.tag] <= 1'b1;
      if (cdb_valid && cdb_ready)
        tag_busy[cdb.tag] <= 1'b0;
    end
  end

  ////////////////////
  // Stimulus

  task automatic drive_cdb_ready();
    forever
    begin
      @(negedge clock);
      cdb_ready = random_phase ? ($urandom_range(0, 3) != 0) : 1'b1;
    end
  endtask

  task automatic wait_drain();
    do
      @(negedge clock);
    while (pending != 0);
  endtask

  task automatic send_alu(input alu_issue_t op);
    op.tag = tag_t'(alu_count % ALU_TAGS);
    alu_count++;
    while (tag_busy[op.tag])
      @(negedge clock);
    alu_issue = op;
    alu_valid = 1'b1;
    do
      @(negedge clock);
    while (!alu_fire);
    alu_valid = 1'b0;
  endtask

  task automatic send_mult(input data_t a, input data_t b);
    mult_issue_t op;
    op = '{tag: tag_t'(ALU_TAGS + mult_count % ALU_TAGS), rob_idx: rob_idx_t'($urandom),
           a: a, b: b};
    mult_count++;
    while (tag_busy[op.tag])
      @(negedge clock);
    mult_issue = op;
    mult_valid = 1'b1;
    do
      @(negedge clock);
    while (!mult_fire);
    mult_valid = 1'b0;
  endtask

  task automatic issue_alu_random();
    alu_issue_t op;
    for (int i = 0; i < NUM_ALU; i++)
    begin
      op.op      = alu_op_t'($urandom_range(0, 8));
      op.rob_idx = rob_idx_t'($urandom);
      op.a       = {$urandom, $urandom};
      op.b       = ($urandom_range(0, 7) == 0) ? op.a : {$urandom, $urandom};  // Some equal pairs
      repeat ($urandom_range(0, 2)) @(negedge clock);
      send_alu(op);
    end
  endtask

  task automatic issue_mult_random();
    for (int i = 0; i < NUM_MULT; i++)
    begin
      repeat ($urandom_range(0, 3)) @(negedge clock);
      send_mult({$urandom, $urandom}, {$urandom, $urandom});
    end
  endtask

  // Lone ALU op, drained before the next
  task automatic alu_one(input alu_op_t op, input data_t a, input data_t b);
    send_alu('{op: op, tag: '0, rob_idx: rob_idx_t'($urandom), a: a, b: b});
    wait_drain();
  endtask

  task automatic run_directed();
    alu_one(ALU_ADD, '1, 64'd1);  // Wraps to zero
    alu_one(ALU_SUB, 64'd0, 64'd1);
    alu_one(ALU_SLL, 64'h8000_0000_0000_0001, 64'd0);
    alu_one(ALU_SLL, 64'h3, 64'd63);
    alu_one(ALU_SRL, '1, 64'd63);
    alu_one(ALU_SRL, 64'h1234, 64'd64);  // Low six bits are zero
    alu_one(ALU_CMPEQ, 64'h55, 64'h55);
    alu_one(ALU_CMPEQ, 64'h55, 64'h56);
    alu_one(ALU_CMPULT, 64'd1, '1);
    alu_one(ALU_CMPULT, '1, 64'd1);
    alu_one(ALU_CMPULT, 64'd7, 64'd7);
    alu_one(ALU_AND, 64'hf0f0_1234_5678_9abc, 64'h0ff0_ffff_0000_ffff);
    alu_one(ALU_OR, 64'hf000_0000_0000_000f, 64'h0f00_0000_0000_00f0);
    alu_one(ALU_XOR, '1, 64'h5555_aaaa_5555_aaaa);
    send_mult(64'd0, {$urandom, $urandom});
    wait_drain();
    send_mult('1, '1);
    wait_drain();
    for (int i = 0; i < 4; i++)
      send_mult({$urandom, $urandom}, {$urandom, $urandom});  // Back to back
    wait_drain();
  endtask

  ////////////////////
  // Run control

  initial
  begin
    void'($urandom(SEED));
    fork
      drive_cdb_ready();
    join_none
    repeat (4) @(negedge clock);
    reset = 1'b0;
    fork
      issue_alu_random();
      issue_mult_random();
    join
    random_phase = 1'b0;
    wait_drain();
    repeat (2) @(negedge clock);
    directed = 1'b1;
    run_directed();
    repeat (5) @(negedge clock);
    $display("Checked %0d of %0d CDB results, %0d errors", checks, NUM_TOTAL, errors);
    if (errors == 0 && checks == NUM_TOTAL)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("Run timed out after %0d cycles with %0d operations outstanding",
             TIMEOUT_CYCLES, pending);
    $display("Checked %0d of %0d CDB results, %0d errors", checks, NUM_TOTAL, errors);
    $display("test failed");
    $finish;
  end

endmodule

// File: sources.f
+incdir+src
src/ex_pkg.sv
src/alu_unit.sv
src/mult_unit.sv
src/cdb_arbiter.sv
src/ex_cluster.sv
dv/ex_checker.sv
dv/tb_ex_cluster.sv

// File: Makefile
SIM      = verilator
TOP      = tb_ex_cluster
FILELIST = sources.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
           --top-module $(TOP) --Mdir $(OBJ_DIR)
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
